// File: all.f
common/rf_cfg_pkg.sv
common/rv_isa_pkg.sv
register_file/rv_register_file.sv
hdl/instr_decode_alu.sv
hdl/mul_ctrl_fsm.sv
hdl/mul_iter_count.sv
hdl/shift_add_mul.sv
hdl/int_exec_top.sv
testbench/tb_clk_gen.sv
testbench/int_exec_asserts.sv
testbench/int_exec_tb.sv

// File: common/rf_cfg_pkg.sv
// Widths are fixed for RV32 with 32 registers; MUL_CYCLES must fit in CNT_W bits
package rf_cfg_pkg;

  // Register file geometry
  localparam int ADDR_W     = 5;
  localparam int DATA_W     = 32;
  localparam int NUM_REGS   = 32;

  // ------------------------------------------------------------
  // Multiplier timing
  // ------------------------------------------------------------
  // One multiplier bit per iteration
  localparam int MUL_CYCLES = 32;
  localparam int CNT_W      = 6;

  // Multiplier control states
  localparam logic [1:0] MST_IDLE  = 2'd0;
  localparam logic [1:0] MST_RUN   = 2'd1;
  localparam logic [1:0] MST_WRITE = 2'd2;

endpackage

// File: common/rv_isa_pkg.sv
// RV32 encodings for the supported subset only: ADD SUB AND OR XOR SLT ADDI MUL
package rv_isa_pkg;

  // ------------------------------------------------------------
  // Major opcodes
  // ------------------------------------------------------------
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // ------------------------------------------------------------
  // funct3 codes
  // ------------------------------------------------------------
  // MUL also uses 000 under F7_MULDIV
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7 codes
  localparam logic [6:0] F7_BASE    = 7'b0000000;
  localparam logic [6:0] F7_SUB     = 7'b0100000;
  localparam logic [6:0] F7_MULDIV  = 7'b0000001;

  // ------------------------------------------------------------
  // Instruction views
  // ------------------------------------------------------------
  // Register-register format
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_instr_t;

  // Immediate format, imm is sign extended by the user
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_instr_t;

  // Opcode, rd, rs1 and funct3 sit in the same bits in both views
  typedef union packed {
    r_instr_t r;
    i_instr_t i;
  } instr_u;

endpackage

// File: hdl/instr_decode_alu.sv
// Decodes one instruction per issue; forwards only from its own writeback stage, not port B
`timescale 1ns/1ns

module instr_decode_alu (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          issue_i,
  input  rv_isa_pkg::instr_u            instr_i,
  output logic [rf_cfg_pkg::ADDR_W-1:0] rs1_o,
  output logic [rf_cfg_pkg::ADDR_W-1:0] rs2_o,
  input  logic [rf_cfg_pkg::DATA_W-1:0] rdata_a_i,
  input  logic [rf_cfg_pkg::DATA_W-1:0] rdata_b_i,
  output logic                          wb_we_o,
  output logic [rf_cfg_pkg::ADDR_W-1:0] wb_rd_o,
  output logic [rf_cfg_pkg::DATA_W-1:0] wb_data_o,
  input  logic                          mul_ready_i,
  output logic                          mul_start_o,
  output logic [rf_cfg_pkg::DATA_W-1:0] mul_op_a_o,
  output logic [rf_cfg_pkg::DATA_W-1:0] mul_op_b_o,
  output logic [rf_cfg_pkg::ADDR_W-1:0] mul_rd_o,
  output logic                          illegal_o
);
  import rv_isa_pkg::*;
  import rf_cfg_pkg::*;

  logic [ADDR_W-1:0] rd;
  logic [DATA_W-1:0] src_a;
  logic [DATA_W-1:0] src_b;
  logic [DATA_W-1:0] imm_sext;
  logic [DATA_W-1:0] op_b;
  logic [DATA_W-1:0] alu_res;
  logic              is_r;
  logic              is_i;
  logic              is_alu;
  logic              is_mul;

  // ------------------------------------------------------------
  // Field extraction, R view for registers, I view for imm
  // ------------------------------------------------------------
  assign rs1_o    = instr_i.r.rs1;
  assign rs2_o    = instr_i.r.rs2;
  assign rd       = instr_i.r.rd;
  assign is_r     = (instr_i.r.opcode == OPC_OP);
  assign is_i     = (instr_i.i.opcode == OPC_OP_IMM);
  assign imm_sext = {{(DATA_W-12){instr_i.i.imm[11]}}, instr_i.i.imm};

  // Forward from writeback stage, its data is already zero for rd x0
  assign src_a = (wb_we_o && wb_rd_o == rs1_o) ? wb_data_o : rdata_a_i;
  assign src_b = (wb_we_o && wb_rd_o == rs2_o) ? wb_data_o : rdata_b_i;
  assign op_b  = is_i ? imm_sext : src_b;

  // ------------------------------------------------------------
  // Classify and compute
  // ------------------------------------------------------------
  always_comb begin
    is_alu  = 1'b0;
    is_mul  = 1'b0;
    alu_res = src_a + op_b;
    if (is_i) begin
      // ADDI only
      is_alu = (instr_i.i.funct3 == F3_ADD_SUB);
    end else if (is_r && instr_i.r.funct7 == F7_MULDIV) begin
      is_mul = (instr_i.r.funct3 == F3_ADD_SUB);
    end else if (is_r && instr_i.r.funct7 == F7_SUB) begin
      is_alu  = (instr_i.r.funct3 == F3_ADD_SUB);
      alu_res = src_a - op_b;
    end else if (is_r && instr_i.r.funct7 == F7_BASE) begin
      is_alu = 1'b1;
      case (instr_i.r.funct3)
        F3_ADD_SUB: alu_res = src_a + op_b;
        F3_AND:     alu_res = src_a & op_b;
        F3_OR:      alu_res = src_a | op_b;
        F3_XOR:     alu_res = src_a ^ op_b;
        F3_SLT:     alu_res = DATA_W'($signed(src_a) < $signed(op_b));
        default:    is_alu = 1'b0;
      endcase
    end
  end

  // Multiplier launch, zero multiplicand gives a zero result for rd x0
  assign mul_start_o = issue_i && is_mul && mul_ready_i;
  assign mul_op_a_o  = (rd == '0) ? '0 : src_a;
  assign mul_op_b_o  = src_b;
  assign mul_rd_o    = rd;

  // ------------------------------------------------------------
  // Writeback stage, drives port A one cycle after issue
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_we_o   <= 1'b0;
      illegal_o <= 1'b0;
    end else begin
      wb_we_o   <= issue_i && is_alu;
      // Unknown encoding, or MUL while the multiplier is busy
      illegal_o <= issue_i && ((!is_alu && !is_mul) || (is_mul && !mul_ready_i));
    end
  end

  always_ff @(posedge clk) begin
    if (issue_i && is_alu) begin
      wb_rd_o   <= rd;
      wb_data_o <= (rd == '0) ? '0 : alu_res;
    end
  end

endmodule

// File: hdl/int_exec_top.sv
// Issuer must avoid hazards on an in-flight MUL rd; no back-pressure on issue
`timescale 1ns/1ns

module int_exec_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          issue_i,
  input  rv_isa_pkg::instr_u            instr_i,
  output logic                          mul_ready_o,
  output logic                          alu_ready_o,
  output logic                          illegal_o,
  output logic                          retire_a_o,
  output logic [rf_cfg_pkg::ADDR_W-1:0] retire_a_rd_o,
  output logic [rf_cfg_pkg::DATA_W-1:0] retire_a_data_o,
  output logic                          retire_b_o,
  output logic [rf_cfg_pkg::ADDR_W-1:0] retire_b_rd_o,
  output logic [rf_cfg_pkg::DATA_W-1:0] retire_b_data_o
);
  import rf_cfg_pkg::*;

  logic [ADDR_W-1:0] rs1;
  logic [ADDR_W-1:0] rs2;
  logic [DATA_W-1:0] rdata_a;
  logic [DATA_W-1:0] rdata_b;
  logic              mul_start;
  logic [DATA_W-1:0] mul_op_a;
  logic [DATA_W-1:0] mul_op_b;
  logic [ADDR_W-1:0] mul_rd;
  logic              cnt_load;
  logic              cnt_last;
  logic              mul_step;
  logic              mul_load;

  // ALU accepts every cycle
  assign alu_ready_o = 1'b1;

  // ------------------------------------------------------------
  // Register file, retire ports are the write ports
  // ------------------------------------------------------------
  rv_register_file u_rf (
    .clk       (clk),
    .rst_n     (rst_n),
    .raddr_a_i (rs1),
    .raddr_b_i (rs2),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .waddr_a_i (retire_a_rd_o),
    .wdata_a_i (retire_a_data_o),
    .we_a_i    (retire_a_o),
    .waddr_b_i (retire_b_rd_o),
    .wdata_b_i (retire_b_data_o),
    .we_b_i    (retire_b_o)
  );

  // Decode and one-cycle ALU
  instr_decode_alu u_dec (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue_i     (issue_i),
    .instr_i     (instr_i),
    .rs1_o       (rs1),
    .rs2_o       (rs2),
    .rdata_a_i   (rdata_a),
    .rdata_b_i   (rdata_b),
    .wb_we_o     (retire_a_o),
    .wb_rd_o     (retire_a_rd_o),
    .wb_data_o   (retire_a_data_o),
    .mul_ready_i (mul_ready_o),
    .mul_start_o (mul_start),
    .mul_op_a_o  (mul_op_a),
    .mul_op_b_o  (mul_op_b),
    .mul_rd_o    (mul_rd),
    .illegal_o   (illegal_o)
  );

  // ------------------------------------------------------------
  // Multiplier
  // ------------------------------------------------------------
  mul_ctrl_fsm u_mul_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (mul_start),
    .rd_i        (mul_rd),
    .cnt_last_i  (cnt_last),
    .cnt_load_o  (cnt_load),
    .step_o      (mul_step),
    .load_o      (mul_load),
    .mul_ready_o (mul_ready_o),
    .we_b_o      (retire_b_o),
    .rd_b_o      (retire_b_rd_o)
  );

  mul_iter_count u_mul_cnt (
    .clk    (clk),
    .rst_n  (rst_n),
    .load_i (cnt_load),
    .en_i   (mul_step),
    .last_o (cnt_last)
  );

  shift_add_mul u_mul_dp (
    .clk       (clk),
    .rst_n     (rst_n),
    .load_i    (mul_load),
    .step_i    (mul_step),
    .op_a_i    (mul_op_a),
    .op_b_i    (mul_op_b),
    .product_o (retire_b_data_o)
  );

endmodule

// File: hdl/mul_ctrl_fsm.sv
// One MUL at a time; a start in RUN is ignored, a start in WRITE launches back to back
`timescale 1ns/1ns

module mul_ctrl_fsm (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          start_i,
  input  logic [rf_cfg_pkg::ADDR_W-1:0] rd_i,
  input  logic                          cnt_last_i,
  output logic                          cnt_load_o,
  output logic                          step_o,
  output logic                          load_o,
  output logic                          mul_ready_o,
  output logic                          we_b_o,
  output logic [rf_cfg_pkg::ADDR_W-1:0] rd_b_o
);
  import rf_cfg_pkg::*;

  logic [1:0] state_q;
  logic [1:0] state_d;
  logic       accept;

  // Ready again in the writeback cycle
  assign mul_ready_o = (state_q != MST_RUN);
  assign accept      = start_i && mul_ready_o;

  // Counter and datapath load together on the issue edge
  assign cnt_load_o = accept;
  assign load_o     = accept;
  assign step_o     = (state_q == MST_RUN);
  assign we_b_o     = (state_q == MST_WRITE);

  // ------------------------------------------------------------
  // Next state
  // ------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      MST_IDLE:  if (accept) state_d = MST_RUN;
      // Last step happens in the same cycle that cnt_last_i is seen
      MST_RUN:   if (cnt_last_i) state_d = MST_WRITE;
      MST_WRITE: state_d = accept ? MST_RUN : MST_IDLE;
      default:   state_d = MST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Destination held until the write, a new capture in WRITE lands on the write edge
  always_ff @(posedge clk) begin
    if (accept) begin
      rd_b_o <= rd_i;
    end
  end

endmodule

// File: hdl/mul_iter_count.sv
// Counts MUL_CYCLES iterations from a load; holds at zero if enabled past the end
`timescale 1ns/1ns

module mul_iter_count (
  input  logic clk,
  input  logic rst_n,
  input  logic load_i,
  input  logic en_i,
  output logic last_o
);
  import rf_cfg_pkg::*;

  logic [CNT_W-1:0] cnt_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= CNT_W'(MUL_CYCLES - 1);
    end else if (en_i && cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Final iteration is the enabled cycle at zero
  assign last_o = en_i && (cnt_q == '0);

endmodule

// File: hdl/shift_add_mul.sv
// Radix-2 shift-add multiplier, one bit per step, low DATA_W bits of the product only
`timescale 1ns/1ns

module shift_add_mul (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          load_i,
  input  logic                          step_i,
  input  logic [rf_cfg_pkg::DATA_W-1:0] op_a_i,
  input  logic [rf_cfg_pkg::DATA_W-1:0] op_b_i,
  output logic [rf_cfg_pkg::DATA_W-1:0] product_o
);
  import rf_cfg_pkg::*;

  logic [DATA_W-1:0] mcand_q;
  logic [DATA_W-1:0] mplier_q;
  logic [DATA_W-1:0] acc_q;

  // ------------------------------------------------------------
  // Iteration
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mcand_q  <= '0;
      mplier_q <= '0;
      acc_q    <= '0;
    end else if (load_i) begin
      mcand_q  <= op_a_i;
      mplier_q <= op_b_i;
      acc_q    <= '0;
    end else if (step_i) begin
      // Add the multiplicand weighted by the current multiplier bit
      if (mplier_q[0]) begin
        acc_q <= acc_q + mcand_q;
      end
      // Bits shifted out of the top only affect the discarded high half
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // Valid once all steps are done
  assign product_o = acc_q;

endmodule

// File: register_file/rv_register_file.sv
// Flip-flop register file, x0 reads zero, port B wins a same-cycle same-register write
`timescale 1ns/1ns

module rv_register_file (
  input  logic                          clk,
  input  logic                          rst_n,
  // Combinational read ports
  input  logic [rf_cfg_pkg::ADDR_W-1:0] raddr_a_i,
  input  logic [rf_cfg_pkg::ADDR_W-1:0] raddr_b_i,
  output logic [rf_cfg_pkg::DATA_W-1:0] rdata_a_o,
  output logic [rf_cfg_pkg::DATA_W-1:0] rdata_b_o,
  // Write port A, ALU results
  input  logic [rf_cfg_pkg::ADDR_W-1:0] waddr_a_i,
  input  logic [rf_cfg_pkg::DATA_W-1:0] wdata_a_i,
  input  logic                          we_a_i,
  // Write port B, multiplier results
  input  logic [rf_cfg_pkg::ADDR_W-1:0] waddr_b_i,
  input  logic [rf_cfg_pkg::DATA_W-1:0] wdata_b_i,
  input  logic                          we_b_i
);
  import rf_cfg_pkg::*;

  logic [DATA_W-1:0]   regs [NUM_REGS];
  logic [NUM_REGS-1:0] we_a_dec;
  logic [NUM_REGS-1:0] we_b_dec;

  // ------------------------------------------------------------
  // Write address decode
  // ------------------------------------------------------------
  // One-hot enable per register, bit 0 is never consumed
  assign we_a_dec = we_a_i ? (NUM_REGS'(1) << waddr_a_i) : '0;
  assign we_b_dec = we_b_i ? (NUM_REGS'(1) << waddr_b_i) : '0;

  // x0 is hard wired
  assign regs[0] = '0;

  // ------------------------------------------------------------
  // Storage for x1..x31
  // ------------------------------------------------------------
  for (genvar i = 1; i < NUM_REGS; i++) begin : g_reg
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        regs[i] <= '0;
      end else if (we_b_dec[i]) begin
        // Multiplier writeback has priority
        regs[i] <= wdata_b_i;
      end else if (we_a_dec[i]) begin
        regs[i] <= wdata_a_i;
      end
    end
  end

  // Reads see the old value during a write cycle
  assign rdata_a_o = regs[raddr_a_i];
  assign rdata_b_o = regs[raddr_b_i];

endmodule

// File: testbench/int_exec_asserts.sv
// Bound to int_exec_top; needs the internal mul_start net, checks only after reset release
`timescale 1ns/1ns

module int_exec_asserts (
  input logic                          clk_i,
  input logic                          rst_n_i,
  input logic                          mul_start_i,
  input logic                          mul_ready_i,
  input logic                          retire_a_i,
  input logic [rf_cfg_pkg::ADDR_W-1:0] retire_a_rd_i,
  input logic [rf_cfg_pkg::DATA_W-1:0] retire_a_data_i,
  input logic                          retire_b_i,
  input logic [rf_cfg_pkg::ADDR_W-1:0] retire_b_rd_i,
  input logic [rf_cfg_pkg::DATA_W-1:0] retire_b_data_i
);
  import rf_cfg_pkg::*;

  int unsigned fail_cnt = 0;
  logic        mul_accept;

  // A MUL is taken only when the FSM is ready
  assign mul_accept = mul_start_i && mul_ready_i;

  // ------------------------------------------------------------
  // Multiplier timing
  // ------------------------------------------------------------
  // Write-back exactly MUL_CYCLES+1 edges after the accepting edge
  a_mul_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mul_accept |=> (!retire_b_i) [*MUL_CYCLES] ##1 retire_b_i)
  else begin
    fail_cnt++;
    $error("retire_b not exactly %0d cycles after MUL accept", MUL_CYCLES + 1);
  end

  // Busy for the whole run, ready again in the write cycle
  a_mul_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mul_accept |=> (!mul_ready_i) [*MUL_CYCLES] ##1 mul_ready_i)
  else begin
    fail_cnt++;
    $error("mul_ready_o high while a MUL is in flight");
  end

  // ------------------------------------------------------------
  // x0 stays zero on both retire ports
  // ------------------------------------------------------------
  a_x0_port_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (retire_a_i && retire_a_rd_i == '0) |-> (retire_a_data_i == '0))
  else begin
    fail_cnt++;
    $error("port A retired nonzero data to x0");
  end

  a_x0_port_b: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (retire_b_i && retire_b_rd_i == '0) |-> (retire_b_data_i == '0))
  else begin
    fail_cnt++;
    $error("port B retired nonzero data to x0");
  end

endmodule

bind int_exec_top int_exec_asserts u_asserts (
  .clk_i           (clk),
  .rst_n_i         (rst_n),
  .mul_start_i     (mul_start),
  .mul_ready_i     (mul_ready_o),
  .retire_a_i      (retire_a_o),
  .retire_a_rd_i   (retire_a_rd_o),
  .retire_a_data_i (retire_a_data_o),
  .retire_b_i      (retire_b_o),
  .retire_b_rd_i   (retire_b_rd_o),
  .retire_b_data_i (retire_b_data_o)
);

// File: testbench/int_exec_tb.sv
// Drives inputs on rising edges and samples at falling edges; stimulus never reads an in-flight MUL rd
`timescale 1ns/1ns

module int_exec_tb;
  import rf_cfg_pkg::*;
  import rv_isa_pkg::*;

  localparam int WAIT_LIMIT = 60;
  localparam int EV_A       = 0;
  localparam int EV_B       = 1;
  localparam int EV_ILL     = 2;

  logic        clk;
  logic        rst_n;
  logic        issue;
  instr_u      instr;
  logic        mul_ready;
  logic        alu_ready;
  logic        illegal;
  logic        retire_a;
  logic [4:0]  retire_a_rd;
  logic [31:0] retire_a_data;
  logic        retire_b;
  logic [4:0]  retire_b_rd;
  logic [31:0] retire_b_data;

  // Reference register file updated in program order
  logic [31:0] model [NUM_REGS];

  // Observed events stamped with the falling-edge count
  int unsigned neg_cnt = 0;
  int unsigned ra_cyc [$];
  logic [4:0]  ra_rd [$];
  logic [31:0] ra_data [$];
  int unsigned rb_cyc [$];
  logic [4:0]  rb_rd [$];
  logic [31:0] rb_data [$];
  logic        rb_rdy [$];
  int unsigned ill_cyc [$];

  int unsigned err_cnt = 0;
  int unsigned chk_cnt = 0;
  int unsigned tests_run = 0;

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  int_exec_top dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .issue_i         (issue),
    .instr_i         (instr),
    .mul_ready_o     (mul_ready),
    .alu_ready_o     (alu_ready),
    .illegal_o       (illegal),
    .retire_a_o      (retire_a),
    .retire_a_rd_o   (retire_a_rd),
    .retire_a_data_o (retire_a_data),
    .retire_b_o      (retire_b),
    .retire_b_rd_o   (retire_b_rd),
    .retire_b_data_o (retire_b_data)
  );

  // ------------------------------------------------------------
  // Falling edge is mid-cycle so outputs are settled
  // ------------------------------------------------------------
  always @(negedge clk) begin
    if (rst_n) begin
      if (retire_a) begin
        ra_cyc.push_back(neg_cnt);
        ra_rd.push_back(retire_a_rd);
        ra_data.push_back(retire_a_data);
      end
      if (retire_b) begin
        rb_cyc.push_back(neg_cnt);
        rb_rd.push_back(retire_b_rd);
        rb_data.push_back(retire_b_data);
        rb_rdy.push_back(mul_ready);
      end
      if (illegal) begin
        ill_cyc.push_back(neg_cnt);
      end
    end
    neg_cnt++;
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout at %0t ns: no %s within %0d cycles", $time, what, WAIT_LIMIT);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  function automatic int pending(input int which);
    int size;
    if (which == EV_A) begin
      size = ra_cyc.size();
    end else if (which == EV_B) begin
      size = rb_cyc.size();
    end else begin
      size = ill_cyc.size();
    end
    return size;
  endfunction

  task automatic wait_event(input int which, input string what);
    int n;
    n = 0;
    while (pending(which) == 0 && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (pending(which) == 0) begin
      abort_on_timeout(what);
    end
  endtask

  // Ready is sampled mid-cycle and stays put until the next rising edge
  task automatic wait_mul_ready();
    int n;
    n = 0;
    @(negedge clk);
    while (!mul_ready && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!mul_ready) begin
      abort_on_timeout("mul_ready_o");
    end
  endtask

  task automatic issue_instr(input logic [31:0] word, output int unsigned stamp);
    @(posedge clk);
    issue <= 1'b1;
    instr <= word;
    stamp = neg_cnt;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    issue <= 1'b0;
  endtask

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_addi(input logic [11:0] imm, input logic [4:0] rd,
                                           input logic [4:0] rs1);
    return {imm, rs1, F3_ADD_SUB, rd, OPC_OP_IMM};
  endfunction

  // Expected result from the model registers by the ISA rules
  function automatic logic [31:0] ref_result(input logic [31:0] word);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    a = model[word[19:15]];
    b = model[word[24:20]];
    res = '0;
    if (word[6:0] == OPC_OP_IMM) begin
      res = a + {{20{word[31]}}, word[31:20]};
    end else if (word[31:25] == F7_MULDIV) begin
      res = a * b;
    end else if (word[31:25] == F7_SUB) begin
      res = a - b;
    end else begin
      case (word[14:12])
        F3_ADD_SUB: res = a + b;
        F3_AND:     res = a & b;
        F3_OR:      res = a | b;
        F3_XOR:     res = a ^ b;
        F3_SLT:     res = {31'b0, $signed(a) < $signed(b)};
        default:    res = '0;
      endcase
    end
    if (word[11:7] == 5'd0) begin
      res = '0;
    end
    return res;
  endfunction

  task automatic expect_retire_a(input int unsigned stamp, input logic [4:0] rd,
                                 input logic [31:0] data);
    wait_event(EV_A, "retire_a");
    check_val("retire_a cycle", ra_cyc.pop_front(), stamp + 1);
    check_val("retire_a rd", ra_rd.pop_front(), rd);
    check_val("retire_a data", ra_data.pop_front(), data);
  endtask

  task automatic expect_retire_b(input int unsigned stamp, input logic [4:0] rd,
                                 input logic [31:0] data);
    wait_event(EV_B, "retire_b");
    check_val("retire_b cycle", rb_cyc.pop_front(), stamp + MUL_CYCLES + 1);
    check_val("retire_b rd", rb_rd.pop_front(), rd);
    check_val("retire_b data", rb_data.pop_front(), data);
    check_val("mul_ready in retire_b cycle", rb_rdy.pop_front(), 1);
  endtask

  // One ALU instruction in isolation and the model follows its result
  task automatic single_alu(input logic [31:0] word);
    int unsigned stamp;
    logic [31:0] exp;
    exp = ref_result(word);
    issue_instr(word, stamp);
    idle_cycle();
    expect_retire_a(stamp, word[11:7], exp);
    model[word[11:7]] = exp;
  endtask

  task automatic finish_test(input string name, input int unsigned errs_before);
    tests_run++;
    $display("Test %s done with %0d errors", name, err_cnt - errs_before);
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic test_reset_state();
    int unsigned e0;
    e0 = err_cnt;
    @(negedge clk);
    check_val("retire_a after reset", retire_a, 0);
    check_val("retire_b after reset", retire_b, 0);
    check_val("illegal after reset", illegal, 0);
    check_val("mul_ready after reset", mul_ready, 1);
    check_val("alu_ready after reset", alu_ready, 1);
    finish_test("reset_state", e0);
  endtask

  task automatic test_alu_ops();
    int unsigned e0;
    logic [31:0] word;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    e0 = err_cnt;
    // Random 12-bit immediates into x1..x8
    for (int r = 1; r <= 8; r++) begin
      single_alu(enc_addi(12'($urandom), 5'(r), 5'd0));
    end
    for (int k = 0; k < 6; k++) begin
      rs1 = 5'($urandom_range(8, 1));
      rs2 = 5'($urandom_range(8, 1));
      case (k)
        0:       word = enc_r(F7_BASE, F3_ADD_SUB, 5'(9 + k), rs1, rs2);
        1:       word = enc_r(F7_SUB, F3_ADD_SUB, 5'(9 + k), rs1, rs2);
        2:       word = enc_r(F7_BASE, F3_AND, 5'(9 + k), rs1, rs2);
        3:       word = enc_r(F7_BASE, F3_OR, 5'(9 + k), rs1, rs2);
        4:       word = enc_r(F7_BASE, F3_XOR, 5'(9 + k), rs1, rs2);
        default: word = enc_r(F7_BASE, F3_SLT, 5'(9 + k), rs1, rs2);
      endcase
      single_alu(word);
    end
    finish_test("alu_ops", e0);
  endtask

  task automatic test_forwarding();
    int unsigned e0;
    logic [31:0] words [4];
    logic [31:0] exps [4];
    int unsigned stamps [4];
    e0 = err_cnt;
    // Each one reads the previous result while it is still in the writeback stage
    words[0] = enc_r(F7_BASE, F3_ADD_SUB, 5'd15, 5'd1, 5'd2);
    words[1] = enc_r(F7_BASE, F3_ADD_SUB, 5'd16, 5'd15, 5'd1);
    words[2] = enc_r(F7_BASE, F3_ADD_SUB, 5'd17, 5'd16, 5'd15);
    words[3] = enc_r(F7_SUB, F3_ADD_SUB, 5'd15, 5'd17, 5'd16);
    for (int i = 0; i < 4; i++) begin
      exps[i] = ref_result(words[i]);
      model[words[i][11:7]] = exps[i];
      issue_instr(words[i], stamps[i]);
    end
    idle_cycle();
    for (int i = 0; i < 4; i++) begin
      expect_retire_a(stamps[i], words[i][11:7], exps[i]);
    end
    finish_test("forwarding", e0);
  endtask

  task automatic test_x0_write();
    int unsigned e0;
    int unsigned mstamp;
    logic [31:0] mword;
    e0 = err_cnt;
    single_alu(enc_addi(12'd123, 5'd0, 5'd1));
    // Multiplier writeback to x0 also retires zero
    mword = enc_r(F7_MULDIV, F3_ADD_SUB, 5'd0, 5'd1, 5'd2);
    wait_mul_ready();
    issue_instr(mword, mstamp);
    idle_cycle();
    expect_retire_b(mstamp, 5'd0, ref_result(mword));
    single_alu(enc_r(F7_BASE, F3_ADD_SUB, 5'd18, 5'd0, 5'd3));
    single_alu(enc_r(F7_BASE, F3_OR, 5'd19, 5'd0, 5'd0));
    finish_test("x0_write", e0);
  endtask

  task automatic test_mul();
    int unsigned e0;
    int unsigned mstamp;
    int unsigned stamps [3];
    logic [31:0] word;
    logic [31:0] mexp;
    logic [31:0] exps [3];
    logic [31:0] awords [3];
    e0 = err_cnt;
    // Second MUL takes the first product as multiplicand
    for (int m = 0; m < 2; m++) begin
      if (m == 0) begin
        word = enc_r(F7_MULDIV, F3_ADD_SUB, 5'd20, 5'd1, 5'd2);
      end else begin
        word = enc_r(F7_MULDIV, F3_ADD_SUB, 5'd21, 5'd20, 5'd3);
      end
      wait_mul_ready();
      mexp = ref_result(word);
      issue_instr(word, mstamp);
      // ALU traffic while the multiplier runs
      for (int k = 0; k < 3; k++) begin
        awords[k] = enc_r(F7_BASE, F3_XOR, 5'(22 + k), 5'($urandom_range(8, 1)),
                          5'($urandom_range(8, 1)));
        exps[k] = ref_result(awords[k]);
        model[awords[k][11:7]] = exps[k];
        issue_instr(awords[k], stamps[k]);
      end
      idle_cycle();
      for (int k = 0; k < 3; k++) begin
        expect_retire_a(stamps[k], awords[k][11:7], exps[k]);
      end
      expect_retire_b(mstamp, word[11:7], mexp);
      model[word[11:7]] = mexp;
    end
    finish_test("mul", e0);
  endtask

  task automatic test_port_priority();
    int unsigned e0;
    int unsigned mstamp;
    int unsigned astamp;
    logic [31:0] mword;
    logic [31:0] aword;
    logic [31:0] mexp;
    logic [31:0] aexp;
    e0 = err_cnt;
    mword = enc_r(F7_MULDIV, F3_ADD_SUB, 5'd25, 5'd3, 5'd4);
    aword = enc_addi(12'd7, 5'd25, 5'd5);
    wait_mul_ready();
    mexp = ref_result(mword);
    aexp = ref_result(aword);
    issue_instr(mword, mstamp);
    // ALU issued so both writes land on the same edge
    repeat (MUL_CYCLES - 1) idle_cycle();
    issue_instr(aword, astamp);
    idle_cycle();
    wait_event(EV_A, "retire_a");
    wait_event(EV_B, "retire_b");
    check_val("port A and B write cycle", ra_cyc[0], rb_cyc[0]);
    expect_retire_a(astamp, 5'd25, aexp);
    expect_retire_b(mstamp, 5'd25, mexp);
    // Port B wins
    model[25] = mexp;
    single_alu(enc_r(F7_BASE, F3_ADD_SUB, 5'd26, 5'd25, 5'd0));
    finish_test("port_priority", e0);
  endtask

  task automatic test_illegal();
    int unsigned e0;
    int unsigned stamp;
    int unsigned mstamp;
    logic [31:0] mword;
    logic [31:0] mexp;
    e0 = err_cnt;
    single_alu(enc_addi(12'h5a5, 5'd27, 5'd0));
    single_alu(enc_addi(12'h3c3, 5'd29, 5'd0));
    // Unknown major opcode aimed at x27
    issue_instr({7'b0, 5'd2, 5'd1, 3'b000, 5'd27, 7'b1111111}, stamp);
    idle_cycle();
    wait_event(EV_ILL, "illegal_o for bad opcode");
    check_val("illegal cycle, bad opcode", ill_cyc.pop_front(), stamp + 1);
    check_val("retire_a count, bad opcode", ra_cyc.size(), 0);
    // Second MUL one cycle after the first while the multiplier is busy
    mword = enc_r(F7_MULDIV, F3_ADD_SUB, 5'd28, 5'd1, 5'd2);
    wait_mul_ready();
    mexp = ref_result(mword);
    issue_instr(mword, mstamp);
    issue_instr(enc_r(F7_MULDIV, F3_ADD_SUB, 5'd29, 5'd3, 5'd4), stamp);
    idle_cycle();
    wait_event(EV_ILL, "illegal_o for busy MUL");
    check_val("illegal cycle, busy MUL", ill_cyc.pop_front(), stamp + 1);
    expect_retire_b(mstamp, 5'd28, mexp);
    model[28] = mexp;
    // Both targets keep their old values
    single_alu(enc_r(F7_BASE, F3_ADD_SUB, 5'd30, 5'd27, 5'd0));
    single_alu(enc_r(F7_BASE, F3_ADD_SUB, 5'd31, 5'd29, 5'd0));
    check_val("retire_b count after drop", rb_cyc.size(), 0);
    finish_test("illegal", e0);
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    int n;
    issue = 1'b0;
    instr = '0;
    n = 0;
    void'($urandom(32'he414782e));
    for (int r = 0; r < NUM_REGS; r++) begin
      model[r] = '0;
    end
    while (!rst_n && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (!rst_n) begin
      abort_on_timeout("reset release");
    end
    test_reset_state();
    test_alu_ops();
    test_forwarding();
    test_x0_write();
    test_mul();
    test_port_priority();
    test_illegal();
    repeat (2) idle_cycle();
    $display("Tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
             tests_run, chk_cnt, err_cnt, dut.u_asserts.fail_cnt);
    if (err_cnt == 0 && dut.u_asserts.fail_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: testbench/tb_clk_gen.sv
// 10 ns free-running clock; reset held low for the first 10 rising edges, then released
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // Clock, 5 ns high and 5 ns low
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset release lands on a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule
